//--- project.f
design/frontend_pkg.sv
design/fetch_unit.sv
design/instr_rom.sv
design/jal_predecoder.sv
design/fetch_queue.sv
design/frontend_top.sv
test/frontend_properties.sv
test/frontend_tb.sv

//--- Bender.yml
package:
  name: frontend

sources:
  - design/frontend_pkg.sv
  - design/fetch_unit.sv
  - design/instr_rom.sv
  - design/jal_predecoder.sv
  - design/fetch_queue.sv
  - design/frontend_top.sv
  - target: test
    files:
      - test/frontend_properties.sv
      - test/frontend_tb.sv

//--- design/rom_image.hex
// one 32-bit instruction word per line, word index 0 to 15 from the top
// word 12 is jal x1, +12 and lands on word 15, the rest are addi
00000013
00100093
00200113
00300193
00400213
00500293
00600313
00700393
00800413
00900493
00a00513
00b00593
00c000ef
00d00693
00e00713
00f00793

//--- test/frontend_tb.sv
// front-end testbench: random pops, redirects and system resets checked against the fetch rules
`timescale 1ns/1ps

module frontend_tb;

    import frontend_pkg::*;

    // distinct redirect targets, each lands on a different rom word
    localparam logic [xlen-1:0] mepc_value  = 32'h0000_0120;
    localparam logic [xlen-1:0] mtvec_value = 32'h0000_0234;
    localparam logic [xlen-1:0] jump_value  = 32'h0000_0308;
    localparam int pop_timeout = 64;

    logic            clk;
    logic            reset_n;
    logic            sys_reset_i;
    redirect_req_t   redirect_i;
    logic [xlen-1:0] mepc_i;
    logic            pop_i;
    logic            valid_o;
    fetch_entry_t    entry_o;

    // model state is the flow the next popped entry belongs to and the pc it must carry
    logic [xlen-1:0] image [rom_words];
    fetch_tag_t      exp_tag;
    logic [xlen-1:0] exp_pc;
    integer          seed;

    frontend_top frontend_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .sys_reset_i (sys_reset_i),
        .redirect_i  (redirect_i),
        .mepc_i      (mepc_i),
        .pop_i       (pop_i),
        .valid_o     (valid_o),
        .entry_o     (entry_o)
    );

    bind frontend_top frontend_properties frontend_properties_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .sys_reset_i (sys_reset_i),
        .pop_i       (pop_i),
        .valid_i     (valid_o),
        .entry_i     (entry_o)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("** Error at %0t ns: %s", $time, msg));
    endtask

    // J immediate as laid out in the RV32I spec, bit 0 always zero
    function automatic logic [xlen-1:0] jal_offset(input logic [xlen-1:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    // machine return first, then trap entry, then jump
    function automatic logic [xlen-1:0] expected_target(input logic jump, input logic exception,
                                                        input logic irq, input logic mret);
        if (mret) begin
            return mepc_value;
        end
        if (exception || irq) begin
            return mtvec_value;
        end
        if (jump) begin
            return jump_value;
        end
        return start_address;
    endfunction

    // compares the entry about to be popped and moves the model on
    task automatic check_popped();
        logic [xlen-1:0] word;
        word = image[entry_o.pc[5:2]];
        assert (entry_o.tag == exp_tag)
            else value_error($sformatf("pc %h has tag %0d, expected %0d",
                                       entry_o.pc, entry_o.tag, exp_tag));
        assert (entry_o.pc == exp_pc)
            else value_error($sformatf("pc %h, expected %h", entry_o.pc, exp_pc));
        assert (entry_o.instr == word)
            else value_error($sformatf("pc %h holds %h, image has %h",
                                       entry_o.pc, entry_o.instr, word));
        // a jal closes its flow, the next entry opens the following tag at the target
        if (word[6:0] == 7'b110_1111) begin
            exp_tag = exp_tag + 3'd1;
            exp_pc  = entry_o.pc + jal_offset(word);
        end else begin
            exp_pc = entry_o.pc + 32'd4;
        end
    endtask

    // random pops create back-pressure, a pop on an empty queue goes through unchecked
    task automatic pop_entries(input int count);
        int          popped;
        int          idle;
        logic [31:0] rnd;
        popped = 0;
        idle   = 0;
        while (popped < count) begin
            @(negedge clk);
            rnd   = $random(seed);
            pop_i = rnd[0];
            if (pop_i && valid_o) begin
                check_popped();
                popped = popped + 1;
                idle   = 0;
            end else begin
                idle = idle + 1;
                if (idle > pop_timeout) begin
                    abort_run("timeout: no entry could be popped from the front end");
                end
            end
        end
        // the last pop lands on the next rising edge
        @(negedge clk);
        pop_i = 1'b0;
    endtask

    // system reset empties the pipe, then an optional redirect leaves it on tag 1
    task automatic system_restart(input logic jump, input logic exception,
                                  input logic irq, input logic mret);
        @(negedge clk);
        pop_i       = 1'b0;
        sys_reset_i = 1'b1;
        repeat (2) @(negedge clk);
        assert (!valid_o) else value_error("valid_o high after system reset");
        sys_reset_i                = 1'b0;
        redirect_i.jump            = jump;
        redirect_i.jump_target     = jump_value;
        redirect_i.exception       = exception;
        redirect_i.interrupt_ack   = irq;
        redirect_i.machine_return  = mret;
        redirect_i.mtvec           = mtvec_value;
        exp_tag = (jump || exception || irq || mret) ? 3'd1 : 3'd0;
        exp_pc  = expected_target(jump, exception, irq, mret);
        @(negedge clk);
        redirect_i = '0;
    endtask

    always @(negedge clk) begin
        if (frontend_i.frontend_properties_i.failures != 0) begin
            abort_run("a bound assertion on the front-end ports failed");
        end
    end

    initial begin
        seed        = 6;
        clk         = 1'b0;
        reset_n     = 1'b0;
        sys_reset_i = 1'b0;
        redirect_i  = '0;
        mepc_i      = mepc_value;
        pop_i       = 1'b0;
        exp_tag     = '0;
        exp_pc      = start_address;
        $readmemh(rom_image_file, image);

        repeat (5) begin
            @(negedge clk);
            assert (!valid_o) else value_error("valid_o high during reset");
        end
        reset_n = 1'b1;

        // a long run hops over enough jal words to wrap the tag
        pop_entries(130);
        // machine return together with exception goes to mepc
        system_restart(1'b0, 1'b1, 1'b0, 1'b1);
        pop_entries(24);
        system_restart(1'b0, 1'b1, 1'b0, 1'b0);
        pop_entries(24);
        system_restart(1'b1, 1'b0, 1'b0, 1'b0);
        pop_entries(24);
        // interrupt acknowledge outranks the jump
        system_restart(1'b1, 1'b0, 1'b1, 1'b0);
        pop_entries(24);
        system_restart(1'b0, 1'b0, 1'b0, 1'b0);
        pop_entries(16);

        if (frontend_i.frontend_properties_i.failures == 0) begin
            $display("No errors");
            $finish;
        end else begin
            abort_run("a bound assertion on the front-end ports failed");
        end
    end

endmodule

//--- test/frontend_properties.sv
// front-end port checker: entries hold under back-pressure and the queue empties on system reset
`timescale 1ns/1ps

module frontend_properties (
    input logic                       clk,
    input logic                       reset_n,
    input logic                       sys_reset_i,
    input logic                       pop_i,
    input logic                       valid_i,
    input frontend_pkg::fetch_entry_t entry_i
);

    // number of failed checks that the testbench watches
    int unsigned failures = 0;

    // an entry that was not taken is still there one cycle later
    valid_held: assert property (@(posedge clk) disable iff (!reset_n)
        valid_i && !pop_i && !sys_reset_i |=> valid_i)
        else begin
            failures++;
            $error("valid dropped while an entry was waiting and no pop came");
        end

    // the consumer must see the same entry until it pops it
    entry_stable: assert property (@(posedge clk) disable iff (!reset_n)
        valid_i && !pop_i && !sys_reset_i |=> $stable(entry_i))
        else begin
            failures++;
            $error("entry changed while valid and not popped");
        end

    // system reset flushes whatever was queued
    flush_on_sys_reset: assert property (@(posedge clk) disable iff (!reset_n)
        sys_reset_i |=> !valid_i)
        else begin
            failures++;
            $error("queue still valid after a system reset");
        end

endmodule

//--- design/frontend_top.sv
// instruction front end: fetch unit, rom, jal predecoder and fetch queue joined by credit flow
`timescale 1ns/1ps

module frontend_top (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          sys_reset_i,
    input  frontend_pkg::redirect_req_t   redirect_i,
    input  logic [frontend_pkg::xlen-1:0] mepc_i,
    input  logic                          pop_i,
    output logic                          valid_o,
    output frontend_pkg::fetch_entry_t    entry_o
);

    import frontend_pkg::*;

    // request path towards the rom
    logic         req_valid;
    fetch_req_t   fetch_req;

    // response path back from the rom
    logic         rsp_valid;
    fetch_entry_t rsp;

    // predecode feedback and flow control
    fetch_tag_t      cur_tag;
    logic            jal_taken;
    logic [xlen-1:0] jal_target;
    logic            enq;
    logic            credit_return;

    fetch_unit fetch_unit_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .sys_reset_i     (sys_reset_i),
        .redirect_i      (redirect_i),
        .mepc_i          (mepc_i),
        .jal_taken_i     (jal_taken),
        .jal_target_i    (jal_target),
        .rsp_valid_i     (rsp_valid),
        .rsp_tag_i       (rsp.tag),
        .credit_return_i (credit_return),
        .req_valid_o     (req_valid),
        .req_o           (fetch_req),
        .cur_tag_o       (cur_tag),
        .enq_o           (enq)
    );

    instr_rom instr_rom_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .req_valid_i (req_valid),
        .req_i       (fetch_req),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp)
    );

    // the predecoder looks at the same response the queue is about to take
    jal_predecoder jal_predecoder_i (
        .rsp_valid_i  (rsp_valid),
        .rsp_i        (rsp),
        .cur_tag_i    (cur_tag),
        .jal_taken_o  (jal_taken),
        .jal_target_o (jal_target)
    );

    fetch_queue fetch_queue_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .sys_reset_i     (sys_reset_i),
        .enq_i           (enq),
        .entry_i         (rsp),
        .pop_i           (pop_i),
        .valid_o         (valid_o),
        .entry_o         (entry_o),
        .credit_return_o (credit_return)
    );

endmodule

//--- design/fetch_queue.sv
// fetch queue: four-entry circular buffer of fetched words, returns one credit per pop
`timescale 1ns/1ps

module fetch_queue (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       sys_reset_i,
    input  logic                       enq_i,
    input  frontend_pkg::fetch_entry_t entry_i,
    input  logic                       pop_i,
    output logic                       valid_o,
    output frontend_pkg::fetch_entry_t entry_o,
    output logic                       credit_return_o
);

    import frontend_pkg::*;

    fetch_entry_t                slots [queue_depth];
    logic [queue_ptr_width-1:0]  wr_ptr;
    logic [queue_ptr_width-1:0]  rd_ptr;
    logic [credit_width-1:0]     count;

    logic push;
    logic pop_ok;

    // there is no full check, the fetch unit never has more requests out than free slots
    assign push   = enq_i && !sys_reset_i;
    // a pop on an empty queue is ignored
    assign pop_ok = pop_i && valid_o && !sys_reset_i;

    assign valid_o         = (count != '0);
    assign entry_o         = slots[rd_ptr];
    assign credit_return_o = pop_ok;

    // storage is written only, the pointers tell which slots hold data
    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= entry_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (sys_reset_i) begin
            // system reset drops everything queued
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // the pointers wrap naturally since the depth is a power of two
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + credit_width'(push) - credit_width'(pop_ok);
        end
    end

endmodule

//--- design/jal_predecoder.sv
// jal predecoder: spots jal in a returned word and computes its target in the same cycle
`timescale 1ns/1ps

module jal_predecoder (
    input  logic                          rsp_valid_i,
    input  frontend_pkg::fetch_entry_t    rsp_i,
    input  frontend_pkg::fetch_tag_t      cur_tag_i,
    output logic                          jal_taken_o,
    output logic [frontend_pkg::xlen-1:0] jal_target_o
);

    import frontend_pkg::*;

    instr_word_u     word;
    logic            is_jal;
    logic [xlen-1:0] j_imm;

    assign word.raw = rsp_i.instr;

    // the opcode sits in the low seven bits of every format
    assign is_jal = (word.j.opcode == opcode_jal);

    // j immediate is scattered over the word, bit 0 is always zero
    assign j_imm = {{11{word.j.imm20}},
                    word.j.imm20,
                    word.j.imm19_12,
                    word.j.imm11,
                    word.j.imm10_1,
                    1'b0};

    assign jal_target_o = rsp_i.pc + j_imm;

    // a jal from a flow that was already redirected must not steer fetch again
    assign jal_taken_o = rsp_valid_i && is_jal && (rsp_i.tag == cur_tag_i);

endmodule

//--- design/instr_rom.sv
// instruction rom: sixteen words from the program image, one cycle read latency
`timescale 1ns/1ps

module instr_rom (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       req_valid_i,
    input  frontend_pkg::fetch_req_t   req_i,
    output logic                       rsp_valid_o,
    output frontend_pkg::fetch_entry_t rsp_o
);

    import frontend_pkg::*;

    logic [xlen-1:0] mem [rom_words];

    initial begin
        $readmemh(rom_image_file, mem);
    end

    // the word index is pc bits 5 to 2, so higher addresses alias onto the image
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            rsp_o.pc    <= req_i.pc;
            rsp_o.tag   <= req_i.tag;
            rsp_o.instr <= mem[req_i.pc[rom_addr_width+1:2]];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= req_valid_i;
        end
    end

endmodule

//--- design/fetch_unit.sv
// fetch unit: picks the next pc by priority, keeps the flow tag and credits, filters stale responses
`timescale 1ns/1ps

module fetch_unit (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              sys_reset_i,
    input  frontend_pkg::redirect_req_t       redirect_i,
    input  logic [frontend_pkg::xlen-1:0]     mepc_i,
    input  logic                              jal_taken_i,
    input  logic [frontend_pkg::xlen-1:0]     jal_target_i,
    input  logic                              rsp_valid_i,
    input  frontend_pkg::fetch_tag_t          rsp_tag_i,
    input  logic                              credit_return_i,
    output logic                              req_valid_o,
    output frontend_pkg::fetch_req_t          req_o,
    output frontend_pkg::fetch_tag_t          cur_tag_o,
    output logic                              enq_o
);

    import frontend_pkg::*;

    logic [xlen-1:0]         pc;
    fetch_tag_t              cur_tag;
    logic [credit_width-1:0] credit_cnt;
    logic [credit_width-1:0] credit_next;

    logic            redirect_taken;
    logic [xlen-1:0] redirect_pc;
    logic            req_fire;
    logic            rsp_stale;

    // machine return beats trap entry, trap entry beats jump, and the predecoded jal comes last
    always_comb begin
        redirect_taken = 1'b1;
        redirect_pc    = jal_target_i;
        if (redirect_i.machine_return) begin
            redirect_pc = mepc_i;
        end else if (redirect_i.exception || redirect_i.interrupt_ack) begin
            redirect_pc = redirect_i.mtvec;
        end else if (redirect_i.jump) begin
            redirect_pc = redirect_i.jump_target;
        end else if (!jal_taken_i) begin
            redirect_taken = 1'b0;
        end
    end

    // no request goes out while the system reset is held, so nothing is in flight afterwards
    assign req_valid_o = (credit_cnt != '0) && !sys_reset_i;
    assign req_fire    = req_valid_o;

    assign req_o.pc  = pc;
    assign req_o.tag = cur_tag;
    assign cur_tag_o = cur_tag;

    // only responses of the current flow go to the queue
    assign enq_o     = rsp_valid_i && (rsp_tag_i == cur_tag) && !sys_reset_i;
    // a response from an older flow is thrown away and hands its credit straight back
    assign rsp_stale = rsp_valid_i && (rsp_tag_i != cur_tag);

    // the queue and the dropped responses give credits back, every request spends one
    assign credit_next = credit_cnt
                       + credit_width'(credit_return_i)
                       + credit_width'(rsp_stale)
                       - credit_width'(req_fire);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc         <= start_address;
            cur_tag    <= '0;
            credit_cnt <= credit_width'(queue_depth);
        end else if (sys_reset_i) begin
            // the queue is flushed in the same cycle, so every credit is home again
            pc         <= start_address;
            cur_tag    <= '0;
            credit_cnt <= credit_width'(queue_depth);
        end else begin
            credit_cnt <= credit_next;
            if (redirect_taken) begin
                // the request in flight now keeps the old tag and will be dropped
                pc      <= redirect_pc;
                cur_tag <= cur_tag + 1'b1;
            end else if (req_fire) begin
                pc <= pc + 32'd4;
            end
        end
    end

endmodule

//--- design/frontend_pkg.sv
// front-end package: widths, fetch types and the instruction-word view shared by all blocks
package frontend_pkg;

    // data and address width of the core
    localparam int xlen = 32;

    // pc after power-on reset and after a system reset
    localparam logic [xlen-1:0] start_address = 32'h0000_0000;

    // the rom holds sixteen words and is addressed by pc bits 5 to 2
    localparam int rom_words      = 16;
    localparam int rom_addr_width = 4;
    localparam string rom_image_file = "design/rom_image.hex";

    // queue depth is also the credit count the fetch unit starts with
    localparam int queue_depth     = 4;
    localparam int queue_ptr_width = $clog2(queue_depth);
    // counters must hold the value queue_depth itself
    localparam int credit_width    = $clog2(queue_depth + 1);

    localparam int tag_width = 3;
    localparam logic [6:0] opcode_jal = 7'b110_1111;

    typedef logic [tag_width-1:0] fetch_tag_t;

    // redirect requests from the back end, mepc travels on its own port
    typedef struct packed {
        logic            jump;
        logic [xlen-1:0] jump_target;
        logic            exception;
        logic            interrupt_ack;
        logic            machine_return;
        logic [xlen-1:0] mtvec;
    } redirect_req_t;

    // one request towards the rom
    typedef struct packed {
        logic [xlen-1:0] pc;
        fetch_tag_t      tag;
    } fetch_req_t;

    // a fetched word together with the pc and flow tag it belongs to
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
        fetch_tag_t      tag;
    } fetch_entry_t;

    // J-type field layout, msb first
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // the same 32-bit word seen whole or split into J-type fields
    typedef union packed {
        logic [xlen-1:0] raw;
        j_type_t         j;
    } instr_word_u;

endpackage
